// ==== hw/glm_cfg_pkg.sv ====
package glm_cfg_pkg;

    // model and labels memories hold 64 lines each
    localparam int line_addr_w = 6;

    localparam int fifo_depth = 16;
    localparam int result_fifo_depth = 8;

    localparam int line_count_w = 16;

    typedef logic [line_addr_w-1:0] line_addr_t;

    // sampled once on op_start
    typedef struct packed
    {
        logic use_forward;
        logic subtract_labels;
        logic [line_count_w-1:0] num_lines;
        line_addr_t model_offset;
        line_addr_t labels_offset;
    } op_cfg_t;

endpackage

// ==== hw/glm_types_pkg.sv ====
package glm_types_pkg;

    localparam int values_per_line = 4;
    localparam int value_w = 16;
    localparam int result_w = 32;

    // one signed lane
    typedef logic signed [value_w-1:0] value_t;

    // lane 0 sits in the low bits
    typedef value_t [values_per_line-1:0] line_t;

    typedef logic signed [result_w-1:0] result_t;

    // one write into a line memory
    typedef struct packed
    {
        logic we;
        glm_cfg_pkg::line_addr_t addr;
        line_t data;
    } mem_write_t;

endpackage

// ==== hw/line_fifo.sv ====
module line_fifo
#(
    parameter type payload_t = glm_types_pkg::line_t,
    parameter int depth = glm_cfg_pkg::fifo_depth
)
(
    input  logic clk,
    input  logic reset,
    input  logic we,
    input  payload_t wdata,
    input  logic re,
    output payload_t rdata,
    output logic rvalid,
    output logic empty,
    output logic full
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_w = $clog2(depth + 1);

    payload_t mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [count_w-1:0] count;

    assign empty = (count == '0);
    assign full = (count == count_w'(depth));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            rvalid <= 1'b0;
        end
        else
        begin
            rvalid <= re;
            if (we)
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (re)
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            if (we && !re)
                count <= count + 1'b1;
            else if (re && !we)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (we)
            mem[wr_ptr] <= wdata;
        if (re)
            rdata <= mem[rd_ptr];
    end

    // readers look at empty before popping
    assert property (@(posedge clk) disable iff (reset) re |-> !empty)
        else $error("line_fifo: read while empty");

endmodule

// ==== hw/line_ram.sv ====
module line_ram
(
    input  logic clk,
    input  glm_types_pkg::mem_write_t write,
    input  logic re,
    input  glm_cfg_pkg::line_addr_t raddr,
    output glm_types_pkg::line_t rdata
);
    localparam int num_lines = 2 ** glm_cfg_pkg::line_addr_w;

    glm_types_pkg::line_t mem [num_lines];

    always_ff @(posedge clk)
    begin
        if (write.we)
            mem[write.addr] <= write.data;
    end

    // data lands one cycle after re
    always_ff @(posedge clk)
    begin
        if (re)
            rdata <= mem[raddr];
    end

endmodule

// ==== hw/vector_subtract.sv ====
module vector_subtract
(
    input  logic clk,
    input  logic reset,
    input  logic trigger,
    input  glm_types_pkg::line_t minuend,
    input  glm_types_pkg::line_t subtrahend,
    output logic result_valid,
    output glm_types_pkg::line_t result
);
    glm_types_pkg::line_t minuend_q;
    glm_types_pkg::line_t subtrahend_q;
    logic operands_valid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            operands_valid <= 1'b0;
            result_valid <= 1'b0;
        end
        else
        begin
            operands_valid <= trigger;
            result_valid <= operands_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        minuend_q <= minuend;
        subtrahend_q <= subtrahend;
        // each lane wraps at 16 bits
        for (int i = 0; i < glm_types_pkg::values_per_line; i++)
            result[i] <= minuend_q[i] - subtrahend_q[i];
    end

endmodule

// ==== hw/dot_accumulate.sv ====
module dot_accumulate
(
    input  logic clk,
    input  logic reset,
    input  logic trigger,
    input  logic [15:0] line_count,
    input  glm_types_pkg::line_t left,
    input  glm_types_pkg::line_t right,
    output logic result_valid,
    output glm_types_pkg::result_t result
);
    glm_types_pkg::result_t prod_q [glm_types_pkg::values_per_line];
    logic prod_valid;
    logic [15:0] count_limit;
    logic [15:0] line_idx;
    logic last_line;
    glm_types_pkg::result_t lane_sum;
    glm_types_pkg::result_t sum_q;

    // lane products in stage one
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < glm_types_pkg::values_per_line; i++)
            prod_q[i] <= $signed(left[i]) * $signed(right[i]);
        // limit travels with the products so a new op can follow
        count_limit <= line_count;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            prod_valid <= 1'b0;
        else
            prod_valid <= trigger;
    end

    always_comb
    begin
        lane_sum = '0;
        for (int i = 0; i < glm_types_pkg::values_per_line; i++)
            lane_sum = lane_sum + prod_q[i];
    end

    assign last_line = (line_idx == count_limit - 16'd1);

    // running sum in stage two wraps at 32 bits
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sum_q <= '0;
            line_idx <= '0;
            result_valid <= 1'b0;
        end
        else
        begin
            result_valid <= prod_valid && last_line;
            if (prod_valid)
            begin
                if (last_line)
                begin
                    sum_q <= '0;
                    line_idx <= '0;
                end
                else
                begin
                    sum_q <= sum_q + lane_sum;
                    line_idx <= line_idx + 16'd1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (prod_valid && last_line)
            result <= sum_q + lane_sum;
    end

endmodule

// ==== hw/glm_dot.sv ====
module glm_dot
(
    input  logic clk,
    input  logic reset,
    input  logic op_start,
    input  glm_cfg_pkg::op_cfg_t op_cfg,
    output logic op_done,
    input  logic in_empty,
    input  glm_types_pkg::line_t in_rdata,
    input  logic fwd_empty,
    input  glm_types_pkg::line_t fwd_rdata,
    input  glm_types_pkg::line_t model_rdata,
    input  glm_types_pkg::line_t labels_rdata,
    output logic in_re,
    output logic fwd_re,
    output logic model_re,
    output glm_cfg_pkg::line_addr_t model_raddr,
    output logic labels_re,
    output glm_cfg_pkg::line_addr_t labels_raddr,
    output logic result_we,
    output glm_types_pkg::result_t result_wdata
);
    typedef enum logic
    {
        st_idle,
        st_read
    } state_t;

    state_t state;
    glm_cfg_pkg::op_cfg_t cfg_q;
    logic [15:0] issued;
    logic [15:0] processed;
    logic issue;
    logic issue_d;

    glm_types_pkg::line_t model_line;
    glm_types_pkg::line_t sample_d1;
    glm_types_pkg::line_t sample_d2;

    logic sub_valid;
    glm_types_pkg::line_t sub_result;

    logic dot_trigger;
    glm_types_pkg::line_t dot_left;
    glm_types_pkg::line_t dot_right;

    // every source of a line is read in the same cycle
    assign issue = (state == st_read) && !in_empty && (issued < cfg_q.num_lines)
        && (!cfg_q.use_forward || !fwd_empty);

    assign in_re = issue;
    assign fwd_re = issue && cfg_q.use_forward;
    assign model_re = issue && !cfg_q.use_forward;
    assign labels_re = issue && cfg_q.subtract_labels;
    assign model_raddr = cfg_q.model_offset + issued[glm_cfg_pkg::line_addr_w-1:0];
    assign labels_raddr = cfg_q.labels_offset + issued[glm_cfg_pkg::line_addr_w-1:0];

    assign model_line = cfg_q.use_forward ? fwd_rdata : model_rdata;

    vector_subtract sub_i
    (
        .clk,
        .reset,
        .trigger(issue_d && cfg_q.subtract_labels),
        .minuend(model_line),
        .subtrahend(labels_rdata),
        .result_valid(sub_valid),
        .result(sub_result)
    );

    // sample waits out the two subtract stages
    always_ff @(posedge clk)
    begin
        sample_d1 <= in_rdata;
        sample_d2 <= sample_d1;
    end

    always_comb
    begin
        if (cfg_q.subtract_labels)
        begin
            dot_trigger = sub_valid;
            dot_left = sub_result;
            dot_right = sample_d2;
        end
        else
        begin
            dot_trigger = issue_d;
            dot_left = model_line;
            dot_right = in_rdata;
        end
    end

    dot_accumulate dot_i
    (
        .clk,
        .reset,
        .trigger(dot_trigger),
        .line_count(cfg_q.num_lines),
        .left(dot_left),
        .right(dot_right),
        .result_valid(result_we),
        .result(result_wdata)
    );

    assign op_done = dot_trigger && (processed == cfg_q.num_lines - 16'd1);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= st_idle;
            cfg_q <= '0;
            issued <= '0;
            processed <= '0;
            issue_d <= 1'b0;
        end
        else
        begin
            issue_d <= issue;
            case (state)
                st_idle:
                begin
                    if (op_start)
                    begin
                        state <= st_read;
                        cfg_q <= op_cfg;
                        issued <= '0;
                        processed <= '0;
                    end
                end
                st_read:
                begin
                    if (issue)
                        issued <= issued + 16'd1;
                    if (dot_trigger)
                        processed <= processed + 16'd1;
                    if (op_done)
                        state <= st_idle;
                end
                default:
                    state <= st_idle;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset) processed <= issued)
        else $error("glm_dot: more lines processed than issued");

    // a trigger outside an operation would mean a stray line
    assert property (@(posedge clk) disable iff (reset) op_done |-> state == st_read)
        else $error("glm_dot: op_done while idle");

endmodule

// ==== hw/glm_dot_top.sv ====
module glm_dot_top
(
    input  logic clk,
    input  logic reset,
    input  logic op_start,
    input  glm_cfg_pkg::op_cfg_t op_cfg,
    output logic op_done,
    input  logic in_we,
    input  glm_types_pkg::line_t in_wdata,
    output logic in_full,
    input  logic fwd_we,
    input  glm_types_pkg::line_t fwd_wdata,
    output logic fwd_full,
    input  glm_types_pkg::mem_write_t model_write,
    input  glm_types_pkg::mem_write_t labels_write,
    input  logic res_re,
    output glm_types_pkg::result_t res_rdata,
    output logic res_empty
);
    logic in_re;
    logic in_empty;
    glm_types_pkg::line_t in_rdata;
    logic fwd_re;
    logic fwd_empty;
    glm_types_pkg::line_t fwd_rdata;
    logic model_re;
    glm_cfg_pkg::line_addr_t model_raddr;
    glm_types_pkg::line_t model_rdata;
    logic labels_re;
    glm_cfg_pkg::line_addr_t labels_raddr;
    glm_types_pkg::line_t labels_rdata;
    logic res_we;
    glm_types_pkg::result_t res_wdata;
    logic res_full;

    line_fifo #(.payload_t(glm_types_pkg::line_t), .depth(glm_cfg_pkg::fifo_depth)) in_fifo
    (
        .clk, .reset,
        .we(in_we), .wdata(in_wdata),
        .re(in_re), .rdata(in_rdata), .rvalid(),
        .empty(in_empty), .full(in_full)
    );

    line_fifo #(.payload_t(glm_types_pkg::line_t), .depth(glm_cfg_pkg::fifo_depth)) fwd_fifo
    (
        .clk, .reset,
        .we(fwd_we), .wdata(fwd_wdata),
        .re(fwd_re), .rdata(fwd_rdata), .rvalid(),
        .empty(fwd_empty), .full(fwd_full)
    );

    line_fifo
    #(
        .payload_t(glm_types_pkg::result_t),
        .depth(glm_cfg_pkg::result_fifo_depth)
    )
    res_fifo
    (
        .clk, .reset,
        .we(res_we), .wdata(res_wdata),
        .re(res_re), .rdata(res_rdata), .rvalid(),
        .empty(res_empty), .full(res_full)
    );

    line_ram model_ram
    (
        .clk, .write(model_write), .re(model_re), .raddr(model_raddr), .rdata(model_rdata)
    );

    line_ram labels_ram
    (
        .clk, .write(labels_write), .re(labels_re), .raddr(labels_raddr), .rdata(labels_rdata)
    );

    glm_dot dot_i
    (
        .clk,
        .reset,
        .op_start,
        .op_cfg,
        .op_done,
        .in_empty,
        .in_rdata,
        .fwd_empty,
        .fwd_rdata,
        .model_rdata,
        .labels_rdata,
        .in_re,
        .fwd_re,
        .model_re,
        .model_raddr,
        .labels_re,
        .labels_raddr,
        .result_we(res_we),
        .result_wdata(res_wdata)
    );

    // results cannot stall so the host has to keep draining
    assert property (@(posedge clk) disable iff (reset) res_we |-> !res_full)
        else $error("glm_dot_top: result written while result FIFO full");

endmodule

// ==== test/glm_dot_model.svh ====
`ifndef glm_dot_model_svh
`define glm_dot_model_svh

// expected dot result of one operation
// models holds the model line paired with each sample, labels the matching label line
function automatic glm_types_pkg::result_t expected_dot
(
    input glm_types_pkg::line_t samples[$],
    input glm_types_pkg::line_t models[$],
    input glm_types_pkg::line_t labels[$],
    input bit subtract
);
    int acc;
    int s;
    int m;
    int diff;
    glm_types_pkg::value_t wrapped;

    acc = 0;
    foreach (samples[i])
    begin
        for (int j = 0; j < glm_types_pkg::values_per_line; j++)
        begin
            s = samples[i][j];
            m = models[i][j];
            if (subtract)
            begin
                // difference is kept to 16 bits, then sign extended again
                diff = m - int'(labels[i][j]);
                wrapped = diff[15:0];
                m = wrapped;
            end
            // int arithmetic wraps modulo 2^32
            acc = acc + s * m;
        end
    end
    return glm_types_pkg::result_t'(acc);
endfunction

`endif

// ==== test/glm_dot_tb.sv ====
module glm_dot_tb;
    timeunit 1ns;
    timeprecision 1ps;

    `include "glm_dot_model.svh"

    localparam int mem_lines = 2 ** glm_cfg_pkg::line_addr_w;
    localparam int op_limit = 2000;
    localparam int full_limit = 500;
    localparam int drain_limit = 500;

    logic clk;
    logic reset;
    logic op_start;
    glm_cfg_pkg::op_cfg_t op_cfg;
    logic op_done;
    logic in_we;
    glm_types_pkg::line_t in_wdata;
    logic in_full;
    logic fwd_we;
    glm_types_pkg::line_t fwd_wdata;
    logic fwd_full;
    glm_types_pkg::mem_write_t model_write;
    glm_types_pkg::mem_write_t labels_write;
    logic res_re;
    glm_types_pkg::result_t res_rdata;
    logic res_empty;

    glm_types_pkg::line_t model_mem [mem_lines];
    glm_types_pkg::line_t labels_mem [mem_lines];
    glm_types_pkg::line_t sample_lines[$];
    glm_types_pkg::line_t fwd_lines[$];
    glm_types_pkg::result_t expected_q[$];

    int errors = 0;
    int checks = 0;
    int done_count = 0;
    int done_before = 0;
    int errors_before = 0;

    glm_dot_top dut_i
    (
        .clk,
        .reset,
        .op_start,
        .op_cfg,
        .op_done,
        .in_we,
        .in_wdata,
        .in_full,
        .fwd_we,
        .fwd_wdata,
        .fwd_full,
        .model_write,
        .labels_write,
        .res_re,
        .res_rdata,
        .res_empty
    );

    always #4 clk = ~clk;

    // op_done is settled by the falling edge
    always @(negedge clk)
    begin
        if (!reset && op_done)
            done_count++;
    end

    task automatic check_value(input string name, input logic [31:0] got,
        input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("FAILED %0t %s got %0d expected %0d", $time, name,
                $signed(got), $signed(exp));
            errors++;
        end
    endtask

    // pops a result whenever the result FIFO holds one
    initial
    begin
        res_re = 1'b0;
        forever
        begin
            @(posedge clk);
            #1;
            if (!reset && !res_empty)
            begin
                res_re = 1'b1;
                @(posedge clk);
                #1;
                res_re = 1'b0;
                if (expected_q.size() == 0)
                begin
                    $display("unexpected result %0d came out of the result FIFO at %0t",
                        res_rdata, $time);
                    errors++;
                end
                else
                    check_value("res_rdata", res_rdata, expected_q.pop_front());
            end
        end
    end

    function automatic glm_types_pkg::line_t random_line();
        glm_types_pkg::line_t line;
        for (int j = 0; j < glm_types_pkg::values_per_line; j++)
            line[j] = glm_types_pkg::value_t'($urandom());
        return line;
    endfunction

    function automatic glm_cfg_pkg::op_cfg_t make_cfg(input bit use_fwd, input bit sub,
        input int n, input int model_off, input int labels_off);
        glm_cfg_pkg::op_cfg_t cfg;
        cfg.use_forward = use_fwd;
        cfg.subtract_labels = sub;
        cfg.num_lines = 16'(n);
        cfg.model_offset = glm_cfg_pkg::line_addr_t'(model_off);
        cfg.labels_offset = glm_cfg_pkg::line_addr_t'(labels_off);
        return cfg;
    endfunction

    task automatic load_memories();
        for (int a = 0; a < mem_lines; a++)
        begin
            model_mem[a] = random_line();
            labels_mem[a] = random_line();
            model_write.we = 1'b1;
            model_write.addr = glm_cfg_pkg::line_addr_t'(a);
            model_write.data = model_mem[a];
            labels_write.we = 1'b1;
            labels_write.addr = glm_cfg_pkg::line_addr_t'(a);
            labels_write.data = labels_mem[a];
            @(posedge clk);
            #1;
        end
        model_write.we = 1'b0;
        labels_write.we = 1'b0;
    endtask

    // pushes sample or forward lines, each after a random gap
    task automatic push_lines(input bit fwd, input int max_gap);
        glm_types_pkg::line_t lines[$];
        int waited;
        if (fwd)
            lines = fwd_lines;
        else
            lines = sample_lines;
        @(posedge clk);
        #1;
        foreach (lines[i])
        begin
            repeat ($urandom_range(0, max_gap))
            begin
                @(posedge clk);
                #1;
            end
            waited = 0;
            while ((fwd ? fwd_full : in_full) && waited < full_limit)
            begin
                @(posedge clk);
                #1;
                waited++;
            end
            if (fwd ? fwd_full : in_full)
            begin
                $display("timeout: %s FIFO stayed full", fwd ? "forward" : "input");
                errors++;
                return;
            end
            if (fwd)
            begin
                fwd_we = 1'b1;
                fwd_wdata = lines[i];
            end
            else
            begin
                in_we = 1'b1;
                in_wdata = lines[i];
            end
            @(posedge clk);
            #1;
            if (fwd)
                fwd_we = 1'b0;
            else
                in_we = 1'b0;
        end
    endtask

    task automatic start_and_wait(input glm_cfg_pkg::op_cfg_t cfg);
        int waited;
        @(posedge clk);
        #1;
        op_cfg = cfg;
        op_start = 1'b1;
        @(posedge clk);
        #1;
        op_start = 1'b0;
        waited = 0;
        while (!op_done && waited < op_limit)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!op_done)
        begin
            $display("timeout: op_done never came for a %0d line operation", cfg.num_lines);
            errors++;
        end
    endtask

    task automatic run_op(input glm_cfg_pkg::op_cfg_t cfg, input int max_gap,
        input bit preload = 1'b0);
        glm_types_pkg::line_t models[$];
        glm_types_pkg::line_t labels[$];
        glm_types_pkg::line_t line;
        sample_lines.delete();
        fwd_lines.delete();
        for (int i = 0; i < int'(cfg.num_lines); i++)
        begin
            sample_lines.push_back(random_line());
            if (cfg.use_forward)
            begin
                line = random_line();
                fwd_lines.push_back(line);
                models.push_back(line);
            end
            else
                models.push_back(model_mem[(int'(cfg.model_offset) + i) % mem_lines]);
            labels.push_back(labels_mem[(int'(cfg.labels_offset) + i) % mem_lines]);
        end
        expected_q.push_back(expected_dot(sample_lines, models, labels, cfg.subtract_labels));
        if (preload)
        begin
            // both FIFOs are filled before the operation starts
            fork
                push_lines(1'b0, max_gap);
                push_lines(1'b1, max_gap);
            join
            check_value("in_full", in_full,
                int'(cfg.num_lines) >= glm_cfg_pkg::fifo_depth);
            check_value("fwd_full", fwd_full,
                cfg.use_forward && int'(cfg.num_lines) >= glm_cfg_pkg::fifo_depth);
            start_and_wait(cfg);
        end
        else
        begin
            fork
                push_lines(1'b0, max_gap);
                push_lines(1'b1, max_gap);
                start_and_wait(cfg);
            join
        end
    endtask

    task automatic finish_test(input int num, input string name, input int ops);
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < drain_limit)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (expected_q.size() != 0)
        begin
            $display("timeout: %0d results never left the result FIFO", expected_q.size());
            errors++;
            expected_q.delete();
        end
        repeat (4) @(posedge clk);
        #1;
        check_value("op_done count", done_count - done_before, ops);
        $display("test %0d %s: %s", num, name, (errors == errors_before) ? "ok" : "failed");
        done_before = done_count;
        errors_before = errors;
    endtask

    initial
    begin
        void'($urandom(59));
        clk = 1'b0;
        reset = 1'b1;
        op_start = 1'b0;
        op_cfg = '0;
        in_we = 1'b0;
        in_wdata = '0;
        fwd_we = 1'b0;
        fwd_wdata = '0;
        model_write = '0;
        labels_write = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        load_memories();

        run_op(make_cfg(0, 0, 7, $urandom_range(0, 63), 0), 0);
        finish_test(1, "model from memory", 1);

        run_op(make_cfg(1, 0, 9, 0, 0), 0);
        finish_test(2, "model from forward FIFO", 1);

        run_op(make_cfg(0, 1, 12, $urandom_range(1, 63), $urandom_range(1, 63)), 0);
        finish_test(3, "memory model minus labels", 1);

        run_op(make_cfg(1, 1, 10, 0, $urandom_range(1, 63)), 0);
        finish_test(4, "forward model minus labels", 1);

        // more lines than the FIFO depth, so pushes overlap the operation
        run_op(make_cfg(1, 1, 20, 0, $urandom_range(0, 63)), 6);
        run_op(make_cfg(0, 0, 24, $urandom_range(0, 63), 0), 5);
        finish_test(5, "random push gaps", 2);

        for (int k = 0; k < 6; k++)
        begin
            run_op(make_cfg($urandom_range(0, 1), $urandom_range(0, 1),
                $urandom_range(1, 12), $urandom_range(0, 63), $urandom_range(0, 63)), 2);
        end
        finish_test(6, "back to back operations", 6);

        run_op(make_cfg(1, 0, glm_cfg_pkg::fifo_depth, 0, 0), 0, 1'b1);
        finish_test(7, "full levels with preloaded FIFOs", 1);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== sources.f ====
hw/glm_cfg_pkg.sv
hw/glm_types_pkg.sv
hw/line_fifo.sv
hw/line_ram.sv
hw/vector_subtract.sv
hw/dot_accumulate.sv
hw/glm_dot.sv
hw/glm_dot_top.sv
+incdir+test
test/glm_dot_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    -f sources.f --top-module glm_dot_tb -o sim_glm_dot
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_glm_dot)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
